// ==== list.f ====
source/isa_pkg.sv
source/mem_pkg.sv
source/mem_if.sv
source/instr_if.sv
source/fetch_unit.sv
source/exec_unit.sv
source/mem_ctrl.sv
source/cpu_top.sv
tb/cpu_checker.sv
tb/tb_cpu.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_cpu
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Testbench failed

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu import isa_pkg::*, mem_pkg::*; ();

  localparam int ADDR_W         = DEF_ADDR_W;
  localparam int PROGRAM_BASE   = DEF_PROGRAM_BASE;
  localparam int N_INSTR        = 24;
  localparam int LOAD_BYTES     = PROGRAM_BASE + N_INSTR * INSTR_BYTES;
  localparam int TIMEOUT_CYCLES = LOAD_BYTES + N_INSTR * 40 + 400;
  localparam int CLK_PERIOD     = 10;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              run;
  logic              load_en;
  logic [ADDR_W-1:0] load_addr;
  byte_t             load_data;
  logic              store_valid;
  logic [ADDR_W-1:0] store_addr;
  byte_t             store_data;

  logic [15:0]       lfsr_q = 16'd30054;
  opcode_e           prog_op   [N_INSTR];
  reg_idx_t          prog_rd   [N_INSTR];
  imm_t              prog_imm  [N_INSTR];
  byte_t             data_init [PROGRAM_BASE];
  logic [ADDR_W-1:0] exp_addr  [$];  // stores in program order
  byte_t             exp_data  [$];
  int                store_idx    = 0;
  int                mismatch_cnt = 0;
  int                other_cnt    = 0;

  cpu_top #(
    .ADDR_W       (ADDR_W),
    .PROGRAM_BASE (PROGRAM_BASE)
  ) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .run         (run),
    .load_en     (load_en),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .store_valid (store_valid),
    .store_addr  (store_addr),
    .store_data  (store_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output int unsigned v);
    v = 0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // random program, reg2ram never reads a register left unset on the taken path
  task automatic build_program();
    int unsigned pick;
    int unsigned r;
    int unsigned imm_raw;
    int          tgt;
    int          next_slot;
    logic [31:0] written;
    next_slot = 0;
    written   = '0;
    for (int a = 0; a < PROGRAM_BASE; a++) begin
      draw_bits(8, r);
      data_init[a] = byte_t'(r);
    end
    for (int i = 0; i < N_INSTR - 1; i++) begin
      draw_bits(3, pick);
      draw_bits(3, r);
      draw_bits(16, imm_raw);
      prog_rd[i] = reg_idx_t'(r);
      tgt = i + 1;
      case (pick)
        0: begin
          draw_bits(5, r);
          tgt = i + 1 + int'(r % (N_INSTR - 1 - i));  // forward only
          prog_op[i]  = OP_JMP;
          prog_imm[i] = imm_t'(PROGRAM_BASE + INSTR_BYTES * tgt);
        end
        1, 2: begin
          prog_op[i]  = OP_RAM2REG;
          prog_imm[i] = imm_t'(imm_raw % PROGRAM_BASE);
        end
        3, 4: begin
          prog_op[i]  = OP_REG2RAM;
          prog_imm[i] = imm_t'(imm_raw % PROGRAM_BASE);
        end
        5, 6: begin
          prog_op[i]  = OP_NUM2REG;
          prog_imm[i] = imm_t'(imm_raw);
        end
        default: begin
          prog_op[i]  = OP_NONE;
          prog_imm[i] = imm_t'(imm_raw);
        end
      endcase
      if (i == next_slot) begin
        if (prog_op[i] == OP_REG2RAM && !written[prog_rd[i]]) begin
          prog_op[i] = OP_NUM2REG;
        end
        if (prog_op[i] == OP_NUM2REG || prog_op[i] == OP_RAM2REG) begin
          written[prog_rd[i]] = 1'b1;
        end
        next_slot = tgt;
      end
    end
    prog_op[N_INSTR-1]  = OP_JMP;  // parks the core
    prog_rd[N_INSTR-1]  = '0;
    prog_imm[N_INSTR-1] = imm_t'(PROGRAM_BASE + INSTR_BYTES * (N_INSTR - 1));
  endtask

  // in-order ISA model, collects the expected stores
  task automatic run_model();
    byte_t    mem [PROGRAM_BASE];
    reg_val_t regs [32];
    int       slot;
    int       addr;
    int       steps;
    logic     done;
    mem   = data_init;
    slot  = 0;
    steps = 0;
    done  = 1'b0;
    while (!done && steps < 4 * N_INSTR) begin
      steps++;
      addr = int'(prog_imm[slot]);
      case (prog_op[slot])
        OP_JMP: begin
          if ((addr - PROGRAM_BASE) / INSTR_BYTES == slot) begin
            done = 1'b1;
          end else begin
            slot = (addr - PROGRAM_BASE) / INSTR_BYTES;
          end
        end
        OP_RAM2REG: begin
          regs[prog_rd[slot]] = {8'h00, mem[addr]};
          slot++;
        end
        OP_REG2RAM: begin
          mem[addr] = regs[prog_rd[slot]][7:0];
          exp_addr.push_back(ADDR_W'(addr));
          exp_data.push_back(regs[prog_rd[slot]][7:0]);
          slot++;
        end
        OP_NUM2REG: begin
          regs[prog_rd[slot]] = prog_imm[slot];
          slot++;
        end
        default: slot++;
      endcase
    end
  endtask

  function automatic byte_t instr_byte(input int slot, input int k);
    case (k)
      0:       instr_byte = byte_t'(prog_op[slot]);
      1:       instr_byte = {3'b000, prog_rd[slot]};
      2:       instr_byte = prog_imm[slot][15:8];
      default: instr_byte = prog_imm[slot][7:0];
    endcase
  endfunction

  task automatic load_byte(input int addr, input byte_t value);
    load_en   = 1'b1;
    load_addr = ADDR_W'(addr);
    load_data = value;
    @(posedge clk);
    #1;
  endtask

  // store port monitor, sampled away from the rising edge
  always @(negedge clk) begin
    if (rst_n && store_valid) begin
      if (!run) begin
        $display("%0t ns: store reported while the core is stopped", $time);
        other_cnt++;
      end
      if (store_idx >= exp_addr.size()) begin
        $display("%0t ns: extra store to address %0d after the program ended",
                 $time, store_addr);
        other_cnt++;
      end else if (store_addr != exp_addr[store_idx] || store_data != exp_data[store_idx]) begin
        $display("MISMATCH %0t ns: store %0d got addr %0d data %02h, expected addr %0d data %02h",
                 $time, store_idx, store_addr, store_data,
                 exp_addr[store_idx], exp_data[store_idx]);
        mismatch_cnt++;
      end
      store_idx++;
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout after %0d cycles, %0d of %0d stores seen",
             TIMEOUT_CYCLES, store_idx, exp_addr.size());
    $display("Testbench failed");
    $finish;
  end

  initial begin
    rst_n     = 1'b0;
    run       = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    build_program();
    run_model();
    $display("program built, %0d stores expected", exp_addr.size());
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int a = 0; a < PROGRAM_BASE; a++) begin
      load_byte(a, data_init[a]);
    end
    for (int i = 0; i < N_INSTR; i++) begin
      for (int k = 0; k < INSTR_BYTES; k++) begin
        load_byte(PROGRAM_BASE + INSTR_BYTES * i + k, instr_byte(i, k));
      end
    end
    load_en = 1'b0;
    run     = 1'b1;
    while (store_idx < exp_addr.size()) begin
      @(negedge clk);
    end
    repeat (200) @(posedge clk);  // core sits on its final jump
    $display("stores %0d of %0d, mismatches %0d, other errors %0d",
             store_idx, exp_addr.size(), mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== tb/cpu_checker.sv ====
`timescale 1ns/1ps

module cpu_checker import mem_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input logic       run,
  input logic       store_valid,
  input logic       ready,
  input logic       busy,
  input logic       redirect,
  input logic       fetch_req,
  input logic       fetch_ack,
  input logic       exec_req,
  input logic       exec_ack,
  input arb_state_e arb_state
);

  // hand-over only while the executor is free
  ready_not_busy: assert property (@(posedge clk) disable iff (!rst_n) !(ready && busy))
    else $error("ready raised while busy is high");

  fetch_ack_req: assert property (@(posedge clk) disable iff (!rst_n) fetch_ack |-> fetch_req)
    else $error("fetch ack without a fetch request");

  exec_ack_req: assert property (@(posedge clk) disable iff (!rst_n) exec_ack |-> exec_req)
    else $error("exec ack without an exec request");

  // exec priority delays a waiting fetch by one grant at most
  fetch_not_starved: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_req && arb_state != ARB_FETCH |-> ##[1:2] fetch_ack)
    else $error("fetch request not acked within two cycles");

  quiet_when_stopped: assert property (@(posedge clk) disable iff (!rst_n)
    !run |-> !store_valid)
    else $error("store reported while run is low");

  redirect_vs_ready: assert property (@(posedge clk) disable iff (!rst_n)
    !(redirect && ready))
    else $error("redirect and ready in the same cycle");

endmodule

bind cpu_top cpu_checker u_checker (
  .clk         (clk),
  .rst_n       (rst_n),
  .run         (run),
  .store_valid (store_valid),
  .ready       (instr.ready),
  .busy        (instr.busy),
  .redirect    (instr.redirect),
  .fetch_req   (fetch_mem.req),
  .fetch_ack   (fetch_mem.ack),
  .exec_req    (exec_mem.req),
  .exec_ack    (exec_mem.ack),
  .arb_state   (u_mem.state_q)
);

// ==== source/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top import mem_pkg::*; #(
  parameter int ADDR_W       = DEF_ADDR_W,        // 8 to 16
  parameter int PROGRAM_BASE = DEF_PROGRAM_BASE
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              run,          // low holds the core, loading allowed
  input  logic              load_en,
  input  logic [ADDR_W-1:0] load_addr,
  input  byte_t             load_data,
  output logic              store_valid,
  output logic [ADDR_W-1:0] store_addr,
  output byte_t             store_data
);

  mem_if   #(.ADDR_W(ADDR_W)) fetch_mem ();
  mem_if   #(.ADDR_W(ADDR_W)) exec_mem ();
  instr_if #(.ADDR_W(ADDR_W)) instr ();

  fetch_unit #(
    .ADDR_W       (ADDR_W),
    .PROGRAM_BASE (PROGRAM_BASE)
  ) u_fetch (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .mem   (fetch_mem.requester),
    .ins   (instr.fetch)
  );

  exec_unit #(.ADDR_W(ADDR_W)) u_exec (
    .clk   (clk),
    .rst_n (rst_n),
    .ins   (instr.exec),
    .mem   (exec_mem.requester)
  );

  mem_ctrl #(.ADDR_W(ADDR_W)) u_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_en     (load_en),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .fetch       (fetch_mem.memory),
    .exec        (exec_mem.memory),
    .store_valid (store_valid),
    .store_addr  (store_addr),
    .store_data  (store_data)
  );

endmodule

// ==== source/mem_ctrl.sv ====
`timescale 1ns/1ps

module mem_ctrl import mem_pkg::*; #(
  parameter int ADDR_W = DEF_ADDR_W
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              load_en,
  input  logic [ADDR_W-1:0] load_addr,
  input  byte_t             load_data,
  mem_if.memory             fetch,
  mem_if.memory             exec,
  output logic              store_valid,
  output logic [ADDR_W-1:0] store_addr,
  output byte_t             store_data
);

  localparam int DEPTH = 2 ** ADDR_W;

  byte_t             ram [DEPTH];
  byte_t             rd_q;
  arb_state_e        state_q;
  arb_state_e        state_d;
  logic              exec_go;   // exec granted this cycle
  logic              fetch_go;  // fetch granted this cycle
  logic [ADDR_W-1:0] rd_addr;

  // the requester acked this cycle still shows req, skip it
  // load port cycles grant nothing
  assign exec_go  = exec.req && state_q != ARB_EXEC && !load_en;
  assign fetch_go = fetch.req && state_q != ARB_FETCH && !load_en && !exec_go;

  always_comb begin
    state_d = ARB_IDLE;
    if (exec_go) begin
      state_d = ARB_EXEC;
    end else if (fetch_go) begin
      state_d = ARB_FETCH;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ARB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign rd_addr = exec_go ? exec.addr : fetch.addr;

  // single write port shared by loader and exec, synchronous read
  always_ff @(posedge clk) begin
    if (load_en) begin
      ram[load_addr] <= load_data;
    end else if (exec_go && exec.we) begin
      ram[exec.addr] <= exec.wdata;
    end
    rd_q <= ram[rd_addr];
  end

  // ack one cycle after the grant, read data with it
  assign fetch.ack   = state_q == ARB_FETCH;
  assign exec.ack    = state_q == ARB_EXEC;
  assign fetch.rdata = rd_q;
  assign exec.rdata  = rd_q;

  // every exec write is reported in its write cycle
  assign store_valid = exec_go && exec.we;
  assign store_addr  = exec.addr;
  assign store_data  = exec.wdata;

endmodule

// ==== source/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit import isa_pkg::*, mem_pkg::*; #(
  parameter int ADDR_W = DEF_ADDR_W
) (
  input  logic clk,
  input  logic rst_n,
  instr_if.exec    ins,
  mem_if.requester mem
);

  reg_val_t regs_q [32];

  logic              busy_q;
  logic              redirect_q;
  logic              req_q;
  logic              we_q;       // 1 for reg2ram, 0 for ram2reg
  logic [ADDR_W-1:0] addr_q;     // jump target or memory address
  byte_t             wdata_q;
  reg_idx_t          rd_q;       // destination of a pending load

  logic              reg_we;
  reg_idx_t          reg_waddr;
  reg_val_t          reg_wdata;

  assign ins.busy     = busy_q;
  assign ins.redirect = redirect_q;
  assign ins.target   = addr_q;

  assign mem.req   = req_q;
  assign mem.we    = we_q;
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata_q;

  // register write port
  // num2reg at ready, ram2reg at the ack of its read
  always_comb begin
    reg_we    = 1'b0;
    reg_waddr = ins.rd;
    reg_wdata = ins.imm;
    if (ins.ready && ins.opcode == OP_NUM2REG) begin
      reg_we = 1'b1;
    end else if (busy_q && !we_q && mem.ack) begin
      reg_we    = 1'b1;
      reg_waddr = rd_q;
      reg_wdata = reg_val_t'(mem.rdata);  // zero-extended byte
    end
  end

  always_ff @(posedge clk) begin
    if (reg_we) begin
      regs_q[reg_waddr] <= reg_wdata;
    end
  end

  // control state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q     <= 1'b0;
      redirect_q <= 1'b0;
      req_q      <= 1'b0;
    end else begin
      redirect_q <= 1'b0;
      if (busy_q && mem.ack) begin
        busy_q <= 1'b0;
        req_q  <= 1'b0;
      end
      // ready only comes while busy is low
      if (ins.ready) begin
        case (ins.opcode)
          OP_JMP: begin
            redirect_q <= 1'b1;
          end
          OP_RAM2REG, OP_REG2RAM: begin
            busy_q <= 1'b1;
            req_q  <= 1'b1;
          end
          default: ;  // num2reg goes through the write port, others do nothing
        endcase
      end
    end
  end

  // operands captured at hand-over
  always_ff @(posedge clk) begin
    if (ins.ready) begin
      addr_q  <= ins.imm[ADDR_W-1:0];  // imm truncated to the address width
      we_q    <= ins.opcode == OP_REG2RAM;
      rd_q    <= ins.rd;
      wdata_q <= regs_q[ins.rd][7:0];   // only the low byte is stored
    end
  end

endmodule

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import isa_pkg::*, mem_pkg::*; #(
  parameter int ADDR_W       = DEF_ADDR_W,
  parameter int PROGRAM_BASE = DEF_PROGRAM_BASE
) (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  mem_if.requester mem,
  instr_if.fetch   ins
);

  typedef enum logic [1:0] {
    F_FETCH,  // reading instruction bytes
    F_HOLD,   // full instruction waiting for the executor
    F_DRAIN   // dropping a read issued before a redirect
  } fetch_state_e;

  fetch_state_e      state_q;
  logic [ADDR_W-1:0] pc_q;       // start of the instruction being fetched
  logic [1:0]        cnt_q;      // byte within the instruction
  logic              req_q;
  logic [ADDR_W-1:0] addr_q;
  byte_t [2:0]       shift_q;    // first three bytes, oldest on top
  opcode_e           opcode_q;
  reg_idx_t          rd_q;
  imm_t              imm_q;

  // hand-over waits for a free executor
  assign ins.ready  = state_q == F_HOLD && !ins.busy;
  assign ins.opcode = opcode_q;
  assign ins.rd     = rd_q;
  assign ins.imm    = imm_q;

  assign mem.req   = req_q;
  assign mem.we    = 1'b0;  // fetch only reads
  assign mem.addr  = addr_q;
  assign mem.wdata = '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= F_FETCH;
      pc_q    <= ADDR_W'(PROGRAM_BASE);
      cnt_q   <= '0;
      req_q   <= 1'b0;
    end else if (ins.redirect) begin
      pc_q  <= ins.target;
      cnt_q <= '0;
      if (req_q && !mem.ack) begin
        state_q <= F_DRAIN;  // ack still to come, data gets thrown away
      end else begin
        state_q <= F_FETCH;
        req_q   <= 1'b0;
      end
    end else begin
      case (state_q)
        F_FETCH: begin
          if (!req_q) begin
            req_q  <= run;
            addr_q <= pc_q + ADDR_W'(cnt_q);
          end else if (mem.ack) begin
            if (cnt_q == 2'd3) begin
              state_q <= F_HOLD;
              req_q   <= 1'b0;
            end else begin
              cnt_q  <= cnt_q + 2'd1;
              req_q  <= run;  // next byte right away
              addr_q <= pc_q + ADDR_W'(cnt_q) + ADDR_W'(1);
            end
          end
        end
        F_HOLD: begin
          if (ins.ready) begin
            state_q <= F_FETCH;
            pc_q    <= pc_q + ADDR_W'(INSTR_BYTES);
            cnt_q   <= '0;
            req_q   <= run;  // overlap next fetch with execution
            addr_q  <= pc_q + ADDR_W'(INSTR_BYTES);
          end
        end
        default: begin
          if (mem.ack) begin
            state_q <= F_FETCH;
            req_q   <= 1'b0;
          end
        end
      endcase
    end
  end

  // instruction assembly
  always_ff @(posedge clk) begin
    if (state_q == F_FETCH && req_q && mem.ack && !ins.redirect) begin
      shift_q <= {shift_q[1:0], mem.rdata};
      if (cnt_q == 2'd3) begin
        opcode_q <= opcode_e'(shift_q[2]);
        rd_q     <= shift_q[1][4:0];
        imm_q    <= {shift_q[0], mem.rdata};
      end
    end
  end

endmodule

// ==== source/instr_if.sv ====
`timescale 1ns/1ps

// decoded instruction from fetch to exec, plus the jump path back
interface instr_if import isa_pkg::*; #(
  parameter int ADDR_W = 10
) ();

  logic              ready;     // strobe, fields valid with it
  opcode_e           opcode;
  reg_idx_t          rd;
  imm_t              imm;
  logic              busy;      // level, memory opcode in flight
  logic              redirect;  // strobe for jumps
  logic [ADDR_W-1:0] target;

  modport fetch (
    output ready, opcode, rd, imm,
    input  busy, redirect, target
  );

  modport exec (
    input  ready, opcode, rd, imm,
    output busy, redirect, target
  );

endinterface

// ==== source/mem_if.sv ====
`timescale 1ns/1ps

// one requester talking to the memory controller
// req, addr, we and wdata are held until the ack strobe
interface mem_if import mem_pkg::*; #(
  parameter int ADDR_W = DEF_ADDR_W
) ();

  logic              req;
  logic              we;
  logic [ADDR_W-1:0] addr;
  byte_t             wdata;
  logic              ack;    // one-cycle strobe
  byte_t             rdata;  // valid with ack on reads

  modport requester (
    output req, we, addr, wdata,
    input  ack, rdata
  );

  modport memory (
    input  req, we, addr, wdata,
    output ack, rdata
  );

endinterface

// ==== source/mem_pkg.sv ====
package mem_pkg;

  typedef logic [7:0] byte_t;

  localparam int DEF_ADDR_W = 10;

  // bytes below the program base form the data area
  localparam int DEF_PROGRAM_BASE = 64;

  // which requester is acked in the current cycle
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_FETCH,
    ARB_EXEC
  } arb_state_e;

endpackage

// ==== source/isa_pkg.sv ====
package isa_pkg;

  // first byte of every instruction
  typedef enum logic [7:0] {
    OP_NONE    = 8'd0,
    OP_JMP     = 8'd1,  // pc <- imm
    OP_RAM2REG = 8'd2,  // reg <- ram[imm], zero-extended
    OP_REG2RAM = 8'd3,  // ram[imm] <- low byte of reg
    OP_NUM2REG = 8'd4   // reg <- imm
  } opcode_e;

  // second byte selects one of 32 registers
  typedef logic [4:0] reg_idx_t;

  typedef logic [15:0] reg_val_t;

  // bytes 3 and 4, high byte first
  typedef logic [15:0] imm_t;

  // opcode, register, imm high, imm low
  localparam int INSTR_BYTES = 4;

endpackage
